/* Bender.yml */
package:
  name: min_heap

sources:
  - include_dirs:
      - .
    files:
      - heap_pkg.sv
      - token_if.sv
      - heap_ctrl.sv
      - heap_stage.sv
      - level_mem.sv
      - min_heap_top.sv

  - target: simulation
    include_dirs:
      - .
    files:
      - tb_min_heap.sv

/* all.f */
+incdir+.
heap_pkg.sv
token_if.sv
heap_ctrl.sv
heap_stage.sv
level_mem.sv
min_heap_top.sv
tb_min_heap.sv

/* heap_ctrl.sv */
// heap controller with root register, ready logic, level 0 token and input checks
`timescale 1ns/1ps
`default_nettype none

`include "heap_defines.svh"

module heap_ctrl import heap_pkg::*; (
   input  logic                        clk,
   input  logic                        rstn,

   input  heap_op_t                    in_op,
   input  logic [`HEAP_KEY_WIDTH-1:0]  in_key,
   input  logic [`HEAP_DATA_WIDTH-1:0] in_data,
   output logic                        ready,

   output heap_entry_t                 root,

   input  logic                        stage_wr_en, // write back from stage 0
   input  heap_entry_t                 stage_wr,

   token_if.src                        tok,
   input  heap_op_t                    cur_op       // op held by stage 0
);

   localparam logic [`HEAP_LEVELS-1:0] FULL_CAP = '1; // all slots free

   heap_entry_t root_nxt;

   // new ops enter level 0 straight from the input
   assign tok.op   = in_op;
   assign tok.pos  = heap_addr_t'(1);
   assign tok.key  = in_key;
   assign tok.data = in_data;

   // stage 0 busy means an op was taken last cycle
   assign ready = (cur_op == NOP);

   always_comb begin
      root_nxt = root;
      if (stage_wr_en) begin
         root_nxt = stage_wr; // sift result from stage 0
      end else if (in_op == REPLACE) begin
         root_nxt.active = 1'b1;
         root_nxt.key    = in_key;
         root_nxt.data   = in_data;
      end else if (in_op == DEQ_MIN) begin
         // stage 0 refills the hole from a child
         root_nxt.active   = 1'b0;
         root_nxt.capacity = root.capacity + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         root <= '{active: 1'b0, capacity: FULL_CAP, key: '0, data: '0};
      end else begin
         root <= root_nxt;
      end
   end

   // sender must wait for ready, there is no back-pressure
   a_no_op_when_busy : assert property (
      @(posedge clk) disable iff (!rstn) !ready |-> (in_op == NOP)
   );

   a_no_enq_when_full : assert property (
      @(posedge clk) disable iff (!rstn) (in_op == ENQ) |-> (root.capacity != '0)
   );

   // removing or replacing needs a valid root
   a_no_remove_when_empty : assert property (
      @(posedge clk) disable iff (!rstn) (in_op inside {REPLACE, DEQ_MIN}) |-> root.active
   );

endmodule

`default_nettype wire

/* heap_defines.svh */
// heap size and entry field width macros
`ifndef HEAP_DEFINES_SVH
`define HEAP_DEFINES_SVH

// number of levels including the root register
// the heap then holds 2**HEAP_LEVELS - 1 entries
// also sets the width of node positions and free-slot counts
`define HEAP_LEVELS 4

// priority key width
// smaller key means higher priority
`define HEAP_KEY_WIDTH 16

// payload carried along with each key
`define HEAP_DATA_WIDTH 8

// entry word is active + capacity + key + data
// 1 + 4 + 16 + 8 = 29 bits with the defaults above

`endif

/* heap_pkg.sv */
// heap operation codes, entry word and node position types
`default_nettype none

`include "heap_defines.svh"

package heap_pkg;

   // operation code on the token pipeline
   // anything other than NOP is a single-cycle strobe
   typedef enum logic [1:0] {
      NOP     = 2'd0,
      ENQ     = 2'd1,
      DEQ_MIN = 2'd2,
      REPLACE = 2'd3
   } heap_op_t;

   // node position, root is 1 and node p has children 2p and 2p+1
   typedef logic [`HEAP_LEVELS-1:0] heap_addr_t;

   // one heap node, also the memory word of a level
   typedef struct packed {
      logic                        active;   // node holds an entry
      logic [`HEAP_LEVELS-1:0]     capacity; // free slots in this subtree
      logic [`HEAP_KEY_WIDTH-1:0]  key;
      logic [`HEAP_DATA_WIDTH-1:0] data;
   } heap_entry_t;

endpackage

`default_nettype wire

/* heap_stage.sv */
// one heap level compare and swap stage for ENQ, DEQ_MIN and REPLACE
`timescale 1ns/1ps
`default_nettype none

`include "heap_defines.svh"

module heap_stage import heap_pkg::*; #(
   parameter int LEVEL = 0
) (
   input  logic        clk,

   token_if.dst        tok_in,
   token_if.src        tok_out,
   output heap_op_t    cur_op,

   input  heap_entry_t node,     // entry at cur_pos
   input  heap_entry_t child_0,  // entry at 2*cur_pos
   input  heap_entry_t child_1,  // entry at 2*cur_pos+1

   output heap_addr_t  node_waddr,
   output heap_addr_t  child_waddr,
   output heap_entry_t node_wdata,
   output heap_entry_t child_wdata,
   output logic        node_wr_en,
   output logic        child_wr_en
);

   heap_addr_t                  cur_pos;
   logic [`HEAP_KEY_WIDTH-1:0]  cur_key;
   logic [`HEAP_DATA_WIDTH-1:0] cur_data;

   heap_addr_t  left_pos;
   heap_addr_t  right_pos;
   logic        go_right;   // ENQ routing
   logic        left_min;   // left child is the smaller one
   logic        node_min;   // node already below both children
   heap_entry_t sel_child;
   heap_addr_t  sel_pos;

   // token captured here, memories return node and children in the same cycle
   always_ff @(posedge clk) begin
      cur_op   <= tok_in.op;
      cur_pos  <= tok_in.pos;
      cur_key  <= tok_in.key;
      cur_data <= tok_in.data;
   end

   assign left_pos  = heap_addr_t'(cur_pos << 1);
   assign right_pos = left_pos | heap_addr_t'(1);

   // right when left is full or right is a smaller active entry with room
   assign go_right = (child_0.capacity == '0) ||
                     (child_1.active && (child_1.capacity != '0) && (child_1.key < cur_key));

   // ties go left
   assign left_min = child_0.active && (!child_1.active || (child_0.key <= child_1.key));

   assign node_min = (!child_0.active || (node.key < child_0.key)) &&
                     (!child_1.active || (node.key < child_1.key));

   assign sel_child = left_min ? child_0 : child_1;
   assign sel_pos   = left_min ? left_pos : right_pos;

   always_comb begin
      tok_out.op   = NOP;
      tok_out.pos  = left_pos;
      tok_out.key  = cur_key;
      tok_out.data = cur_data;

      node_waddr  = cur_pos;
      child_waddr = sel_pos;
      node_wdata  = node;
      child_wdata = sel_child;
      node_wr_en  = 1'b0;
      child_wr_en = 1'b0;

      case (cur_op)
         ENQ: begin
            node_wr_en          = 1'b1;
            node_wdata.capacity = node.capacity - 1'b1; // one more slot used below here
            if (!node.active) begin
               node_wdata.active = 1'b1; // empty slot found, op ends here
               node_wdata.key    = cur_key;
               node_wdata.data   = cur_data;
            end else begin
               tok_out.op = ENQ;
               if (cur_key < node.key) begin
                  // keep the smaller entry and push the old one down
                  node_wdata.key  = cur_key;
                  node_wdata.data = cur_data;
                  tok_out.key     = node.key;
                  tok_out.data    = node.data;
               end
               if (go_right) begin
                  tok_out.pos = right_pos;
               end
            end
         end

         DEQ_MIN: begin
            if (child_0.active || child_1.active) begin
               // pull the smaller child up, the hole moves down
               tok_out.op           = DEQ_MIN;
               tok_out.pos          = sel_pos;
               node_wr_en           = 1'b1;
               node_wdata.active    = 1'b1;
               node_wdata.key       = sel_child.key;
               node_wdata.data      = sel_child.data;
               child_wr_en          = 1'b1;
               child_wdata.active   = 1'b0;
               child_wdata.capacity = sel_child.capacity + 1'b1;
            end
         end

         REPLACE: begin
            if (!node_min) begin
               // swap node with smaller child, capacities stay
               tok_out.op       = REPLACE;
               tok_out.pos      = sel_pos;
               node_wr_en       = 1'b1;
               node_wdata.key   = sel_child.key;
               node_wdata.data  = sel_child.data;
               child_wr_en      = 1'b1;
               child_wdata.key  = node.key;
               child_wdata.data = node.data;
            end
         end

         default: begin
         end
      endcase
   end

   // an ENQ that reaches the leaf level always finds an empty slot there
   a_enq_ends_at_leaf : assert property (
      @(posedge clk) (LEVEL == `HEAP_LEVELS - 1) && (cur_op == ENQ) |-> !node.active
   );

   // ENQ is only routed into subtrees with a free slot
   a_enq_has_room : assert property (
      @(posedge clk) (cur_op == ENQ) |-> (node.capacity != '0)
   );

endmodule

`default_nettype wire

/* level_mem.sv */
// two-bank node memory of one heap level with port muxing and write bypass
`timescale 1ns/1ps
`default_nettype none

`include "heap_defines.svh"

module level_mem import heap_pkg::*; #(
   parameter int LEVEL = 1
) (
   input  logic        clk,
   input  logic        rstn,

   token_if.dst        parent_tok,  // token entering the stage above
   token_if.dst        own_tok,     // token entering this level's stage

   output heap_entry_t child_0,     // even bank, to the stage above
   output heap_entry_t child_1,     // odd bank, to the stage above
   output heap_entry_t node,        // to this level's stage

   input  heap_addr_t  parent_waddr,
   input  heap_entry_t parent_wdata,
   input  logic        parent_wr_en,

   input  heap_addr_t  own_waddr,
   input  heap_entry_t own_wdata,
   input  logic        own_wr_en
);

   localparam int DEPTH = 2 ** (LEVEL - 1);             // words per bank
   localparam int IDX_W = (LEVEL > 1) ? LEVEL - 1 : 1;
   localparam int CAP_W = `HEAP_LEVELS;
   localparam logic [CAP_W-1:0] INIT_CAP = CAP_W'((2 ** (`HEAP_LEVELS - LEVEL)) - 1);
   localparam heap_entry_t INIT_WORD = '{active: 1'b0, capacity: INIT_CAP, key: '0, data: '0};

   heap_addr_t       raddr;
   heap_addr_t       waddr;
   heap_entry_t      wdata;
   heap_entry_t      wdata_q;   // last write, replayed on a same-address read
   logic             wr_en;
   logic             rsel_q;    // bank of the node read last cycle
   logic [IDX_W-1:0] ridx;
   logic [IDX_W-1:0] widx;

   // word index inside a bank
   // bit 0 picks the bank and the level's leading one is masked off
   function automatic logic [IDX_W-1:0] bank_idx(input heap_addr_t addr);
      return IDX_W'((addr >> 1) & heap_addr_t'(DEPTH - 1));
   endfunction

   // own token and parent token are never active together
   assign raddr = (own_tok.op != NOP) ? own_tok.pos : heap_addr_t'(parent_tok.pos << 1);

   assign waddr = own_wr_en ? own_waddr : parent_waddr;
   assign wdata = own_wr_en ? own_wdata : parent_wdata;
   assign wr_en = own_wr_en || parent_wr_en;

   assign ridx = bank_idx(raddr);
   assign widx = bank_idx(waddr);

   always_ff @(posedge clk) begin
      wdata_q <= wdata;
      rsel_q  <= raddr[0];
   end

   for (genvar b = 0; b < 2; b++) begin : g_bank
      heap_entry_t mem [DEPTH] = '{default: INIT_WORD}; // empty subtrees at start
      heap_entry_t mem_q;
      heap_entry_t rd;
      logic        we;
      logic        hit_q;

      assign we = wr_en && (waddr[0] == 1'(b));

      always_ff @(posedge clk) begin
         if (we) begin
            mem[widx] <= wdata;
         end
         mem_q <= mem[ridx]; // read before write
      end

      always_ff @(posedge clk) begin
         if (!rstn) begin
            hit_q <= 1'b0;
         end else begin
            hit_q <= we && (widx == ridx);
         end
      end

      assign rd = hit_q ? wdata_q : mem_q;
   end

   assign child_0 = g_bank[0].rd;
   assign child_1 = g_bank[1].rd;
   assign node    = rsel_q ? g_bank[1].rd : g_bank[0].rd;

   // issue spacing keeps adjacent stages off this level's write port
   a_single_writer : assert property (
      @(posedge clk) disable iff (!rstn) !(parent_wr_en && own_wr_en)
   );

endmodule

`default_nettype wire

/* min_heap_top.sv */
// pipelined min-heap top with controller, level stages and level memories
`timescale 1ns/1ps
`default_nettype none

`include "heap_defines.svh"

module min_heap_top import heap_pkg::*; (
   input  logic                        clk,
   input  logic                        rstn,

   input  heap_op_t                    in_op,
   input  logic [`HEAP_KEY_WIDTH-1:0]  in_key,
   input  logic [`HEAP_DATA_WIDTH-1:0] in_data,
   output logic                        ready,

   output logic [`HEAP_KEY_WIDTH-1:0]  out_key,
   output logic [`HEAP_DATA_WIDTH-1:0] out_data,
   output logic                        out_valid,
   output logic [`HEAP_LEVELS-1:0]     capacity
);

   localparam int N = `HEAP_LEVELS;
   localparam heap_entry_t NO_CHILD = '0; // inactive, no room

   token_if tok [N+1] ();  // tok[i] feeds stage i

   heap_op_t    cur_op      [N];
   heap_entry_t node        [N]; // node[0] is the root register
   heap_entry_t child_0     [N];
   heap_entry_t child_1     [N];
   heap_addr_t  node_waddr  [N];
   heap_addr_t  child_waddr [N];
   heap_entry_t node_wdata  [N];
   heap_entry_t child_wdata [N];
   logic        node_wr_en  [N];
   logic        child_wr_en [N];

   heap_ctrl u_ctrl (
      .clk         (clk),
      .rstn        (rstn),
      .in_op       (in_op),
      .in_key      (in_key),
      .in_data     (in_data),
      .ready       (ready),
      .root        (node[0]),
      .stage_wr_en (node_wr_en[0]),
      .stage_wr    (node_wdata[0]),
      .tok         (tok[0]),
      .cur_op      (cur_op[0])
   );

   // last level has no children below it
   assign child_0[N-1] = NO_CHILD;
   assign child_1[N-1] = NO_CHILD;

   for (genvar i = 0; i < N; i++) begin : g_level
      heap_stage #(.LEVEL(i)) u_stage (
         .clk         (clk),
         .tok_in      (tok[i]),
         .tok_out     (tok[i+1]),
         .cur_op      (cur_op[i]),
         .node        (node[i]),
         .child_0     (child_0[i]),
         .child_1     (child_1[i]),
         .node_waddr  (node_waddr[i]),
         .child_waddr (child_waddr[i]),
         .node_wdata  (node_wdata[i]),
         .child_wdata (child_wdata[i]),
         .node_wr_en  (node_wr_en[i]),
         .child_wr_en (child_wr_en[i])
      );

      if (i > 0) begin : g_mem
         level_mem #(.LEVEL(i)) u_mem (
            .clk          (clk),
            .rstn         (rstn),
            .parent_tok   (tok[i-1]),
            .own_tok      (tok[i]),
            .child_0      (child_0[i-1]),
            .child_1      (child_1[i-1]),
            .node         (node[i]),
            .parent_waddr (child_waddr[i-1]),
            .parent_wdata (child_wdata[i-1]),
            .parent_wr_en (child_wr_en[i-1]),
            .own_waddr    (node_waddr[i]),
            .own_wdata    (node_wdata[i]),
            .own_wr_en    (node_wr_en[i])
         );
      end
   end

   assign out_key   = node[0].key;
   assign out_data  = node[0].data;
   assign out_valid = node[0].active;
   assign capacity  = node[0].capacity; // free slots in the whole heap

endmodule

`default_nettype wire

/* tb_min_heap.sv */
// table-driven testbench for the pipelined min-heap with clock, reset, check task and timeout
`timescale 1ns/1ps
`default_nettype none

`include "heap_defines.svh"

module tb_min_heap import heap_pkg::*; ();

   // one stimulus row with the outputs expected once ready returns
   typedef struct packed {
      heap_op_t                    op;
      logic [`HEAP_KEY_WIDTH-1:0]  key;
      logic [`HEAP_DATA_WIDTH-1:0] data;
      logic                        exp_valid;
      logic [`HEAP_KEY_WIDTH-1:0]  exp_key;
      logic [`HEAP_DATA_WIDTH-1:0] exp_data;
      logic [`HEAP_LEVELS-1:0]     exp_cap;
   } row_t;

   logic                        clk;
   logic                        rstn;
   heap_op_t                    in_op;
   logic [`HEAP_KEY_WIDTH-1:0]  in_key;
   logic [`HEAP_DATA_WIDTH-1:0] in_data;
   logic                        ready;
   logic [`HEAP_KEY_WIDTH-1:0]  out_key;
   logic [`HEAP_DATA_WIDTH-1:0] out_data;
   logic                        out_valid;
   logic [`HEAP_LEVELS-1:0]     capacity;

   row_t rows [$];
   int   cycles = 0;
   int   limit  = 0;   // set once the table is built
   int   wait_cnt;

   min_heap_top UUT (
      .clk       (clk),
      .rstn      (rstn),
      .in_op     (in_op),
      .in_key    (in_key),
      .in_data   (in_data),
      .ready     (ready),
      .out_key   (out_key),
      .out_data  (out_data),
      .out_valid (out_valid),
      .capacity  (capacity)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // run limit in clock cycles
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("timeout: ready did not come back within %0d cycles", limit);
         $display("Simulation failed");
         $fatal(1, "run stopped on timeout");
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
         $display("Simulation failed");
         $fatal(1, "output mismatch");
      end
   endtask

   task automatic add_row(input heap_op_t op, input logic [`HEAP_KEY_WIDTH-1:0] key,
                          input logic [`HEAP_DATA_WIDTH-1:0] data, input logic exp_valid,
                          input logic [`HEAP_KEY_WIDTH-1:0] exp_key,
                          input logic [`HEAP_DATA_WIDTH-1:0] exp_data,
                          input logic [`HEAP_LEVELS-1:0] exp_cap);
      rows.push_back(row_t'{op, key, data, exp_valid, exp_key, exp_data, exp_cap});
   endtask

   // expected root is the smallest key held, capacity counts free slots of 15
   task automatic build_table();
      add_row(ENQ,     16'h0500, 8'h15, 1'b1, 16'h0500, 8'h15, 14);
      add_row(ENQ,     16'h0200, 8'h12, 1'b1, 16'h0200, 8'h12, 13);
      add_row(ENQ,     16'h0c00, 8'h1c, 1'b1, 16'h0200, 8'h12, 12);
      add_row(ENQ,     16'h0100, 8'h11, 1'b1, 16'h0100, 8'h11, 11);
      add_row(ENQ,     16'h0800, 8'h18, 1'b1, 16'h0100, 8'h11, 10);
      add_row(REPLACE, 16'h0d80, 8'h2d, 1'b1, 16'h0200, 8'h12, 10); // 0100 leaves
      add_row(ENQ,     16'h0e00, 8'h1e, 1'b1, 16'h0200, 8'h12, 9);
      add_row(ENQ,     16'h0300, 8'h13, 1'b1, 16'h0200, 8'h12, 8);
      add_row(ENQ,     16'h0f00, 8'h1f, 1'b1, 16'h0200, 8'h12, 7);
      add_row(ENQ,     16'h0a00, 8'h1a, 1'b1, 16'h0200, 8'h12, 6);
      add_row(ENQ,     16'h0600, 8'h16, 1'b1, 16'h0200, 8'h12, 5);
      add_row(ENQ,     16'h0d00, 8'h1d, 1'b1, 16'h0200, 8'h12, 4);
      add_row(ENQ,     16'h0400, 8'h14, 1'b1, 16'h0200, 8'h12, 3);
      add_row(ENQ,     16'h0b00, 8'h1b, 1'b1, 16'h0200, 8'h12, 2);
      add_row(ENQ,     16'h0700, 8'h17, 1'b1, 16'h0200, 8'h12, 1);
      add_row(ENQ,     16'h0900, 8'h19, 1'b1, 16'h0200, 8'h12, 0);  // heap full
      add_row(DEQ_MIN, 16'h0000, 8'h00, 1'b1, 16'h0300, 8'h13, 1);
      add_row(DEQ_MIN, 16'h0000, 8'h00, 1'b1, 16'h0400, 8'h14, 2);
      add_row(DEQ_MIN, 16'h0000, 8'h00, 1'b1, 16'h0500, 8'h15, 3);
      add_row(DEQ_MIN, 16'h0000, 8'h00, 1'b1, 16'h0600, 8'h16, 4);
      add_row(DEQ_MIN, 16'h0000, 8'h00, 1'b1, 16'h0700, 8'h17, 5);
      add_row(DEQ_MIN, 16'h0000, 8'h00, 1'b1, 16'h0800, 8'h18, 6);
      add_row(DEQ_MIN, 16'h0000, 8'h00, 1'b1, 16'h0900, 8'h19, 7);
      add_row(DEQ_MIN, 16'h0000, 8'h00, 1'b1, 16'h0a00, 8'h1a, 8);
      add_row(DEQ_MIN, 16'h0000, 8'h00, 1'b1, 16'h0b00, 8'h1b, 9);
      add_row(DEQ_MIN, 16'h0000, 8'h00, 1'b1, 16'h0c00, 8'h1c, 10);
      add_row(DEQ_MIN, 16'h0000, 8'h00, 1'b1, 16'h0d00, 8'h1d, 11);
      add_row(DEQ_MIN, 16'h0000, 8'h00, 1'b1, 16'h0d80, 8'h2d, 12);
      add_row(DEQ_MIN, 16'h0000, 8'h00, 1'b1, 16'h0e00, 8'h1e, 13);
      add_row(DEQ_MIN, 16'h0000, 8'h00, 1'b1, 16'h0f00, 8'h1f, 14);
      add_row(DEQ_MIN, 16'h0000, 8'h00, 1'b0, 16'h0000, 8'h00, 15); // empty again
   endtask

   initial begin
      rstn    = 1'b0;
      in_op   = NOP;
      in_key  = '0;
      in_data = '0;
      build_table();
      limit = 4 * rows.size() + 20;

      repeat (2) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);
      check_value("ready", ready, 1'b1);
      check_value("out_valid", out_valid, 1'b0);
      check_value("capacity", capacity, 15);

      foreach (rows[i]) begin
         while (!ready) @(negedge clk);
         @(posedge clk);
         in_op   <= rows[i].op;
         in_key  <= rows[i].key;
         in_data <= rows[i].data;
         @(posedge clk);          // DUT takes the op at this edge
         in_op <= NOP;
         wait_cnt = 0;
         do begin
            @(negedge clk);
            wait_cnt++;
         end while (!ready);
         // low for one cycle after the issue edge, then high again
         check_value("ready_cycles", wait_cnt, 2);
         check_value("out_valid", out_valid, rows[i].exp_valid);
         if (rows[i].exp_valid) begin
            check_value("out_key", out_key, rows[i].exp_key);
            check_value("out_data", out_data, rows[i].exp_data);
         end
         check_value("capacity", capacity, rows[i].exp_cap);
      end

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

/* token_if.sv */
// operation token passed from one heap level to the next
`timescale 1ns/1ps
`default_nettype none

`include "heap_defines.svh"

interface token_if import heap_pkg::*; ();

   heap_op_t                    op;   // NOP when idle
   heap_addr_t                  pos;  // node this op works on at the receiving level
   logic [`HEAP_KEY_WIDTH-1:0]  key;  // entry being pushed down on ENQ
   logic [`HEAP_DATA_WIDTH-1:0] data;

   // stage or controller driving the token
   modport src (output op, pos, key, data);

   // next stage and level memory reading it
   modport dst (input op, pos, key, data);

endinterface

`default_nettype wire
